/* rtl/mem_pkg.sv */
package mem_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 8;
	localparam int BYTE_SEL_W = 4;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [ALU_OP_W-1:0]   alu_op_t;
	typedef logic [BYTE_SEL_W-1:0] byte_sel_t; // bit 3 is the msb lane
	typedef logic [31:0]           exc_code_t;
	typedef logic [4:0]            cp0_addr_t;
	typedef logic [1:0]            access_size_t;
	typedef logic [2:0]            access_kind_t;

	// load/store op codes as issued by execute
	localparam alu_op_t OP_LB  = 8'b1110_0000;
	localparam alu_op_t OP_LBU = 8'b1110_0100;
	localparam alu_op_t OP_LH  = 8'b1110_0001;
	localparam alu_op_t OP_LHU = 8'b1110_0101;
	localparam alu_op_t OP_LW  = 8'b1110_0011;
	localparam alu_op_t OP_LWL = 8'b1110_0010;
	localparam alu_op_t OP_LWR = 8'b1110_0110;
	localparam alu_op_t OP_SB  = 8'b1110_1000;
	localparam alu_op_t OP_SH  = 8'b1110_1001;
	localparam alu_op_t OP_SW  = 8'b1110_1011;
	localparam alu_op_t OP_SWL = 8'b1110_1010;
	localparam alu_op_t OP_SWR = 8'b1110_1110;

	localparam exc_code_t EXC_NONE    = 32'h0000_0000;
	localparam exc_code_t EXC_ADEL    = 32'h0000_0004;
	localparam exc_code_t EXC_ADES    = 32'h0000_0005;
	localparam exc_code_t EXC_SYSCALL = 32'h0000_0008;
	localparam exc_code_t EXC_RI      = 32'h0000_000a;
	localparam exc_code_t EXC_CPU     = 32'h0000_000b;
	localparam exc_code_t EXC_ERET    = 32'h0000_000e;
	localparam exc_code_t EXC_INT     = 32'h0000_000f;

	// flag positions in excepttype_i from earlier stages
	localparam int EXC_FLAG_SYSCALL = 8;
	localparam int EXC_FLAG_RI      = 10;
	localparam int EXC_FLAG_CPU     = 11;
	localparam int EXC_FLAG_ERET    = 12;

	localparam cp0_addr_t CP0_STATUS = 5'd12;
	localparam cp0_addr_t CP0_CAUSE  = 5'd13;
	localparam cp0_addr_t CP0_EPC    = 5'd14;

	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;

	localparam access_size_t SIZE_BYTE = 2'd0;
	localparam access_size_t SIZE_HALF = 2'd1;
	localparam access_size_t SIZE_WORD = 2'd2;

	localparam access_kind_t KIND_NONE    = 3'd0;
	localparam access_kind_t KIND_LOAD    = 3'd1;
	localparam access_kind_t KIND_LOAD_L  = 3'd2; // lwl
	localparam access_kind_t KIND_LOAD_R  = 3'd3; // lwr
	localparam access_kind_t KIND_STORE   = 3'd4;
	localparam access_kind_t KIND_STORE_L = 3'd5; // swl
	localparam access_kind_t KIND_STORE_R = 3'd6; // swr

endpackage

/* rtl/mem_access_if.sv */
`timescale 1ns/1ns

// decoded access, plain levels from decode to execute
interface mem_access_if;
	import mem_pkg::*;

	access_kind_t kind;
	access_size_t size;
	logic sign_ext;
	logic misaligned; // execute blanks the access on this

	modport decode (
		output kind,
		output size,
		output sign_ext,
		output misaligned
	);

	modport execute (
		input kind,
		input size,
		input sign_ext,
		input misaligned
	);

endinterface

/* rtl/mem_decode.sv */
`timescale 1ns/1ns

module mem_decode (
	input mem_pkg::alu_op_t aluop_i,
	input logic [1:0] addr_lsb_i,
	mem_access_if.decode acc,
	output logic adel_o,
	output logic ades_o
);
	import mem_pkg::*;

	always_comb begin
		case (aluop_i)
			OP_LB, OP_LBU, OP_SB: acc.size = SIZE_BYTE;
			OP_LH, OP_LHU, OP_SH: acc.size = SIZE_HALF;
			default: acc.size = SIZE_WORD; // lw/sw and the left/right forms
		endcase

		case (aluop_i)
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: acc.kind = KIND_LOAD;
			OP_LWL: acc.kind = KIND_LOAD_L;
			OP_LWR: acc.kind = KIND_LOAD_R;
			OP_SB, OP_SH, OP_SW: acc.kind = KIND_STORE;
			OP_SWL: acc.kind = KIND_STORE_L;
			OP_SWR: acc.kind = KIND_STORE_R;
			default: acc.kind = KIND_NONE;
		endcase

		acc.sign_ext = (aluop_i == OP_LB) || (aluop_i == OP_LH);

		// only plain loads and stores can fault, lwl/lwr/swl/swr take any offset
		acc.misaligned = 1'b0;
		if ((acc.kind == KIND_LOAD) || (acc.kind == KIND_STORE)) begin
			if (acc.size == SIZE_HALF) begin
				acc.misaligned = addr_lsb_i[0];
			end else if (acc.size == SIZE_WORD) begin
				acc.misaligned = (addr_lsb_i != 2'b00);
			end
		end

		adel_o = acc.misaligned && (acc.kind == KIND_LOAD);
		ades_o = acc.misaligned && (acc.kind == KIND_STORE);

		// a single access is either a load or a store, never both faults
		assert (!(adel_o && ades_o))
			else $error("mem_decode: adel and ades raised together");
	end

endmodule

/* rtl/mem_execute.sv */
`timescale 1ns/1ns

module mem_execute #(
	parameter int DATA_W = 32
) (
	mem_access_if.execute acc,
	input mem_pkg::word_t mem_addr_i,
	input mem_pkg::word_t reg2_i,
	input mem_pkg::word_t mem_data_i,
	output mem_pkg::word_t mem_addr_o,
	output mem_pkg::word_t mem_data_o,
	output mem_pkg::word_t load_data_o,
	output mem_pkg::byte_sel_t mem_sel_o,
	output logic mem_ce_o,
	output logic store_o
);
	import mem_pkg::*;

	localparam int LANES = DATA_W / 8;

	logic [1:0] off;
	logic active;
	logic [DATA_W-1:0] mem_shl; // memory moved up by the offset
	logic [DATA_W-1:0] mem_shr; // addressed byte ends up in lane 0
	logic [DATA_W-1:0] lwl_data;
	logic [DATA_W-1:0] lwr_data;
	logic [7:0] byte_val;
	logic [15:0] half_val;

	assign off = mem_addr_i[1:0];
	assign active = (acc.kind != KIND_NONE) && !acc.misaligned;
	assign mem_shl = mem_data_i << (8 * off);
	assign mem_shr = mem_data_i >> (8 * (LANES - 1 - int'(off)));
	assign byte_val = mem_shr[7:0];
	assign half_val = off[1] ? mem_data_i[15:0] : mem_data_i[DATA_W-1 -: 16];

	// unaligned merge, lane by lane: memory lanes on one side, reg2 keeps the rest
	always_comb begin
		for (int b = 0; b < LANES; b++) begin
			lwl_data[8*b +: 8] = (b >= int'(off)) ? mem_shl[8*b +: 8] : reg2_i[8*b +: 8];
			lwr_data[8*b +: 8] = (b <= int'(off)) ? mem_shr[8*b +: 8] : reg2_i[8*b +: 8];
		end
	end

	always_comb begin
		mem_addr_o = mem_addr_i;
		mem_sel_o = '0;
		mem_data_o = '0;
		load_data_o = '0;
		case (acc.kind)
			KIND_LOAD, KIND_STORE: begin
				case (acc.size)
					SIZE_BYTE: begin
						mem_sel_o = 4'b1000 >> off;
						mem_data_o = {LANES{reg2_i[7:0]}};
						load_data_o = {{(DATA_W-8){acc.sign_ext & byte_val[7]}}, byte_val};
					end
					SIZE_HALF: begin
						mem_sel_o = off[1] ? 4'b0011 : 4'b1100;
						mem_data_o = {(LANES/2){reg2_i[15:0]}};
						load_data_o = {{(DATA_W-16){acc.sign_ext & half_val[15]}}, half_val};
					end
					default: begin
						mem_sel_o = '1;
						mem_data_o = reg2_i;
						load_data_o = mem_data_i;
					end
				endcase
				if (acc.kind == KIND_LOAD) begin
					mem_data_o = '0; // nothing on the write bus for a read
				end
			end
			KIND_LOAD_L, KIND_LOAD_R: begin
				mem_addr_o = {mem_addr_i[DATA_W-1:2], 2'b00};
				mem_sel_o = '1; // whole word is read, merge happens here
				load_data_o = (acc.kind == KIND_LOAD_L) ? lwl_data : lwr_data;
			end
			KIND_STORE_L: begin
				mem_addr_o = {mem_addr_i[DATA_W-1:2], 2'b00};
				mem_sel_o = 4'b1111 >> off;
				mem_data_o = reg2_i >> (8 * off);
			end
			KIND_STORE_R: begin
				mem_addr_o = {mem_addr_i[DATA_W-1:2], 2'b00};
				mem_sel_o = 4'b1111 << (2'd3 - off);
				mem_data_o = reg2_i << (8 * (LANES - 1 - int'(off)));
			end
			default: mem_addr_o = '0;
		endcase

		if (!active) begin
			mem_sel_o = '0;
			mem_data_o = '0;
			load_data_o = '0;
		end
		mem_ce_o = active;
		store_o = active && (acc.kind inside {KIND_STORE, KIND_STORE_L, KIND_STORE_R});

		assert (!mem_ce_o || (mem_sel_o != '0))
			else $error("mem_execute: chip enable with no byte lane");
	end

endmodule

/* rtl/mem_result.sv */
`timescale 1ns/1ns

module mem_result #(
	parameter int DATA_W = 32
) (
	input logic clk,
	input logic rst_i,
	input mem_pkg::reg_addr_t wd_i,
	input logic wreg_i,
	input logic load_i,
	input mem_pkg::word_t load_data_i,
	input mem_pkg::word_t wdata_i,
	input logic store_i,
	input logic adel_i,
	input logic ades_i,
	input mem_pkg::word_t mem_addr_i,
	input mem_pkg::word_t excepttype_i,
	input mem_pkg::word_t current_inst_address_i,
	input mem_pkg::word_t cp0_status_i,
	input mem_pkg::word_t cp0_cause_i,
	input mem_pkg::word_t cp0_epc_i,
	input logic wb_cp0_reg_we_i,
	input mem_pkg::cp0_addr_t wb_cp0_reg_write_addr_i,
	input mem_pkg::word_t wb_cp0_reg_data_i,
	output logic mem_we_o,
	output mem_pkg::reg_addr_t wd_o,
	output logic wreg_o,
	output mem_pkg::word_t wdata_o,
	output mem_pkg::exc_code_t excepttype_o,
	output mem_pkg::word_t bad_v_addr_o,
	output mem_pkg::word_t cp0_epc_o
);
	import mem_pkg::*;

	word_t status;
	word_t cause;
	word_t epc;
	exc_code_t exc_code;
	logic int_pending;
	logic [DATA_W-1:0] wb_result;

	// writeback may be writing cp0 this very cycle, take its value instead
	function automatic word_t fwd(input logic we, input cp0_addr_t waddr, input word_t wdata,
			input cp0_addr_t reg_num, input word_t cur);
		return (we && (waddr == reg_num)) ? wdata : cur;
	endfunction

	assign status = fwd(wb_cp0_reg_we_i, wb_cp0_reg_write_addr_i, wb_cp0_reg_data_i,
			CP0_STATUS, cp0_status_i);
	assign cause = fwd(wb_cp0_reg_we_i, wb_cp0_reg_write_addr_i, wb_cp0_reg_data_i,
			CP0_CAUSE, cp0_cause_i);
	assign epc = fwd(wb_cp0_reg_we_i, wb_cp0_reg_write_addr_i, wb_cp0_reg_data_i,
			CP0_EPC, cp0_epc_i);

	// pending & mask, not already in exception level, interrupts on
	assign int_pending = ((cause[15:8] & status[15:8]) != 8'h00) &&
			!status[STATUS_EXL] && status[STATUS_IE];

	always_comb begin
		exc_code = EXC_NONE;
		if (current_inst_address_i != '0) begin // bubble has no address
			if (int_pending) exc_code = EXC_INT;
			else if (adel_i) exc_code = EXC_ADEL;
			else if (ades_i) exc_code = EXC_ADES;
			else if (excepttype_i[EXC_FLAG_SYSCALL]) exc_code = EXC_SYSCALL;
			else if (excepttype_i[EXC_FLAG_RI]) exc_code = EXC_RI;
			else if (excepttype_i[EXC_FLAG_CPU]) exc_code = EXC_CPU;
			else if (excepttype_i[EXC_FLAG_ERET]) exc_code = EXC_ERET;
		end
	end

	assign mem_we_o = store_i && (exc_code == EXC_NONE); // exception cancels the write
	assign wb_result = load_i ? load_data_i : wdata_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wd_o <= '0;
			wreg_o <= 1'b0;
			wdata_o <= {DATA_W{1'b0}};
			excepttype_o <= EXC_NONE;
			bad_v_addr_o <= '0;
			cp0_epc_o <= '0;
		end else begin
			wd_o <= wd_i;
			wreg_o <= wreg_i;
			wdata_o <= wb_result;
			excepttype_o <= exc_code;
			bad_v_addr_o <= (adel_i || ades_i) ? mem_addr_i : '0;
			cp0_epc_o <= epc;
		end
	end

	// a store that reached memory must not show up as an exception at mem/wb
	assert property (@(posedge clk) disable iff (rst_i)
			mem_we_o |=> (excepttype_o == EXC_NONE))
		else $error("mem_result: store written but exception registered");

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage #(
	parameter int DATA_W = 32
) (
	input logic clk,
	input logic rst_i,
	input mem_pkg::alu_op_t aluop_i,
	input mem_pkg::word_t mem_addr_i,
	input mem_pkg::word_t reg2_i,
	input mem_pkg::reg_addr_t wd_i,
	input logic wreg_i,
	input mem_pkg::word_t wdata_i,
	input mem_pkg::word_t mem_data_i,
	input mem_pkg::word_t excepttype_i,
	input mem_pkg::word_t current_inst_address_i,
	input mem_pkg::word_t cp0_status_i,
	input mem_pkg::word_t cp0_cause_i,
	input mem_pkg::word_t cp0_epc_i,
	input logic wb_cp0_reg_we_i,
	input mem_pkg::cp0_addr_t wb_cp0_reg_write_addr_i,
	input mem_pkg::word_t wb_cp0_reg_data_i,
	output mem_pkg::word_t mem_addr_o,
	output mem_pkg::byte_sel_t mem_sel_o,
	output mem_pkg::word_t mem_data_o,
	output logic mem_ce_o,
	output logic mem_we_o,
	output mem_pkg::reg_addr_t wd_o,
	output logic wreg_o,
	output mem_pkg::word_t wdata_o,
	output mem_pkg::exc_code_t excepttype_o,
	output mem_pkg::word_t bad_v_addr_o,
	output mem_pkg::word_t cp0_epc_o
);
	import mem_pkg::*;

	logic adel;
	logic ades;
	logic ce;
	logic store;
	logic store_en;
	logic is_load;
	word_t load_data;

	mem_access_if acc ();

	assign is_load = acc.kind inside {KIND_LOAD, KIND_LOAD_L, KIND_LOAD_R};
	assign mem_ce_o = ce & ~rst_i; // ram stays idle during reset
	assign store_en = store & ~rst_i;

	mem_decode u_decode (
		.aluop_i(aluop_i),
		.addr_lsb_i(mem_addr_i[1:0]),
		.acc(acc.decode),
		.adel_o(adel),
		.ades_o(ades)
	);

	mem_execute #(.DATA_W(DATA_W)) u_execute (
		.acc(acc.execute),
		.mem_addr_i(mem_addr_i),
		.reg2_i(reg2_i),
		.mem_data_i(mem_data_i),
		.mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o),
		.load_data_o(load_data),
		.mem_sel_o(mem_sel_o),
		.mem_ce_o(ce),
		.store_o(store)
	);

	mem_result #(.DATA_W(DATA_W)) u_result (
		.clk(clk),
		.rst_i(rst_i),
		.wd_i(wd_i),
		.wreg_i(wreg_i),
		.load_i(is_load),
		.load_data_i(load_data),
		.wdata_i(wdata_i),
		.store_i(store_en),
		.adel_i(adel),
		.ades_i(ades),
		.mem_addr_i(mem_addr_i),
		.excepttype_i(excepttype_i),
		.current_inst_address_i(current_inst_address_i),
		.cp0_status_i(cp0_status_i),
		.cp0_cause_i(cp0_cause_i),
		.cp0_epc_i(cp0_epc_i),
		.wb_cp0_reg_we_i(wb_cp0_reg_we_i),
		.wb_cp0_reg_write_addr_i(wb_cp0_reg_write_addr_i),
		.wb_cp0_reg_data_i(wb_cp0_reg_data_i),
		.mem_we_o(mem_we_o),
		.wd_o(wd_o),
		.wreg_o(wreg_o),
		.wdata_o(wdata_o),
		.excepttype_o(excepttype_o),
		.bad_v_addr_o(bad_v_addr_o),
		.cp0_epc_o(cp0_epc_o)
	);

endmodule

/* tb/mem_checker.sv */
`timescale 1ns/1ns

module mem_checker (
	input logic clk,
	input logic rst_i,
	input mem_pkg::alu_op_t aluop_i,
	input mem_pkg::word_t mem_addr_i,
	input mem_pkg::word_t reg2_i,
	input mem_pkg::reg_addr_t wd_i,
	input logic wreg_i,
	input mem_pkg::word_t wdata_i,
	input mem_pkg::word_t mem_data_i,
	input mem_pkg::word_t excepttype_i,
	input mem_pkg::word_t current_inst_address_i,
	input mem_pkg::word_t cp0_status_i,
	input mem_pkg::word_t cp0_cause_i,
	input mem_pkg::word_t cp0_epc_i,
	input logic wb_cp0_reg_we_i,
	input mem_pkg::cp0_addr_t wb_cp0_reg_write_addr_i,
	input mem_pkg::word_t wb_cp0_reg_data_i,
	input mem_pkg::word_t mem_addr_o,
	input mem_pkg::byte_sel_t mem_sel_o,
	input mem_pkg::word_t mem_data_o,
	input logic mem_ce_o,
	input logic mem_we_o,
	input mem_pkg::reg_addr_t wd_o,
	input logic wreg_o,
	input mem_pkg::word_t wdata_o,
	input mem_pkg::exc_code_t excepttype_o,
	input mem_pkg::word_t bad_v_addr_o,
	input mem_pkg::word_t cp0_epc_o
);
	import mem_pkg::*;

	int bus_errors = 0;
	int reg_errors = 0;
	int cycles_checked = 0;
	logic reset_seen = 1'b0;

	logic [7:0] cls; // ld st left right sign size[2:0]
	logic ld, st, lft, rgt, mis, intr;
	logic [2:0] nb;
	logic [1:0] off;
	int sh;
	logic [7:0] bv;
	logic [15:0] hv;
	word_t status, cause, epc, e_addr, e_data, ld_val;
	byte_sel_t e_sel;
	logic e_ce, e_we;
	exc_code_t code;
	logic exp_valid = 1'b0;
	logic x_reset;
	reg_addr_t x_wd;
	logic x_wreg;
	word_t x_wdata, x_bad, x_epc;
	exc_code_t x_code;

	task automatic compare_bus(input string what, input word_t got, input word_t want);
		if (got !== want) begin
			bus_errors++;
			$display("error at %0t: %s is %h, expected %h (op %h addr %h)",
				$time, what, got, want, aluop_i, mem_addr_i);
		end
	endtask

	task automatic compare_reg(input string what, input word_t got, input word_t want);
		if (got !== want) begin
			reg_errors++;
			$display("error at %0t: registered %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// bus side is stable here, inputs only move on the falling edge
	always @(posedge clk) begin
		if (rst_i) begin
			compare_bus("mem_ce_o in reset", 32'(mem_ce_o), 32'd0);
			compare_bus("mem_we_o in reset", 32'(mem_we_o), 32'd0);
			x_reset = 1'b1;
			x_wd = '0;
			x_wreg = 1'b0;
			x_wdata = '0;
			x_code = EXC_NONE;
			x_bad = '0;
			x_epc = '0;
		end else begin
			case (aluop_i)
				OP_LB:   cls = 8'b1_0_0_0_1_001;
				OP_LBU:  cls = 8'b1_0_0_0_0_001;
				OP_LH:   cls = 8'b1_0_0_0_1_010;
				OP_LHU:  cls = 8'b1_0_0_0_0_010;
				OP_LW:   cls = 8'b1_0_0_0_0_100;
				OP_LWL:  cls = 8'b1_0_1_0_0_100;
				OP_LWR:  cls = 8'b1_0_0_1_0_100;
				OP_SB:   cls = 8'b0_1_0_0_0_001;
				OP_SH:   cls = 8'b0_1_0_0_0_010;
				OP_SW:   cls = 8'b0_1_0_0_0_100;
				OP_SWL:  cls = 8'b0_1_1_0_0_100;
				OP_SWR:  cls = 8'b0_1_0_1_0_100;
				default: cls = 8'b0_0_0_0_0_100;
			endcase
			{ld, st, lft, rgt} = cls[7:4];
			nb = cls[2:0];
			off = mem_addr_i[1:0];
			sh = 8 * int'(off);
			mis = (ld || st) && !lft && !rgt && (({1'b0, off} & (nb - 3'd1)) != 3'd0);
			bv = mem_data_i[31 - sh -: 8]; // offset 0 is the msb lane
			hv = mem_data_i[31 - sh -: 16];

			e_addr = mem_addr_i;
			if (!(ld || st))
				e_addr = '0;
			else if (lft || rgt)
				e_addr = {mem_addr_i[31:2], 2'b00};
			e_sel = '0;
			e_data = '0;
			ld_val = '0;
			if ((ld || st) && !mis) begin
				if (lft && ld) begin
					e_sel = 4'hf;
					ld_val = (mem_data_i << sh) | (reg2_i & ~(32'hffff_ffff << sh));
				end else if (rgt && ld) begin
					e_sel = 4'hf;
					ld_val = (mem_data_i >> (24 - sh)) | (reg2_i & ~(32'hffff_ffff >> (24 - sh)));
				end else if (lft) begin
					e_sel = 4'hf >> off;
					e_data = reg2_i >> sh;
				end else if (rgt) begin
					e_sel = ~(4'b0111 >> off);
					e_data = reg2_i << (24 - sh);
				end else if (nb == 3'd1) begin
					e_sel = 4'b0001 << (3 - off);
					e_data = {4{reg2_i[7:0]}};
					ld_val = {{24{bv[7] & cls[3]}}, bv};
				end else if (nb == 3'd2) begin
					e_sel = off[1] ? 4'b0011 : 4'b1100;
					e_data = {2{reg2_i[15:0]}};
					ld_val = {{16{hv[15] & cls[3]}}, hv};
				end else begin
					e_sel = 4'hf;
					e_data = reg2_i;
					ld_val = mem_data_i;
				end
				if (ld)
					e_data = '0;
			end

			// cp0 values as seen after the writeback write
			status = cp0_status_i;
			cause = cp0_cause_i;
			epc = cp0_epc_i;
			if (wb_cp0_reg_we_i && wb_cp0_reg_write_addr_i == CP0_STATUS)
				status = wb_cp0_reg_data_i;
			if (wb_cp0_reg_we_i && wb_cp0_reg_write_addr_i == CP0_CAUSE)
				cause = wb_cp0_reg_data_i;
			if (wb_cp0_reg_we_i && wb_cp0_reg_write_addr_i == CP0_EPC)
				epc = wb_cp0_reg_data_i;
			intr = ((cause[15:8] & status[15:8]) != 8'h00) && !status[1] && status[0];

			code = 32'h0;
			if (current_inst_address_i != 32'h0) begin
				if (intr)
					code = 32'h0f;
				else if (mis && ld)
					code = 32'h04;
				else if (mis && st)
					code = 32'h05;
				else if (excepttype_i[8])
					code = 32'h08;
				else if (excepttype_i[10])
					code = 32'h0a;
				else if (excepttype_i[11])
					code = 32'h0b;
				else if (excepttype_i[12])
					code = 32'h0e;
			end
			e_ce = (ld || st) && !mis;
			e_we = st && !mis && (code == 32'h0); // exception cancels the store

			compare_bus("mem_addr_o", mem_addr_o, e_addr);
			compare_bus("mem_sel_o", 32'(mem_sel_o), 32'(e_sel));
			compare_bus("mem_data_o", mem_data_o, e_data);
			compare_bus("mem_ce_o", 32'(mem_ce_o), 32'(e_ce));
			compare_bus("mem_we_o", 32'(mem_we_o), 32'(e_we));

			x_reset = 1'b0;
			x_wd = wd_i;
			x_wreg = wreg_i;
			x_wdata = ld ? ld_val : wdata_i;
			x_code = code;
			x_bad = mis ? mem_addr_i : 32'h0;
			x_epc = epc;
		end
		exp_valid = 1'b1;
	end

	// registered side settled half a cycle after the edge
	always @(negedge clk) begin
		if (exp_valid) begin
			compare_reg("wd_o", 32'(wd_o), 32'(x_wd));
			compare_reg("wreg_o", 32'(wreg_o), 32'(x_wreg));
			compare_reg("wdata_o", wdata_o, x_wdata);
			compare_reg("excepttype_o", excepttype_o, x_code);
			compare_reg("bad_v_addr_o", bad_v_addr_o, x_bad);
			compare_reg("cp0_epc_o", cp0_epc_o, x_epc);
			if (x_reset)
				reset_seen = 1'b1;
			else
				cycles_checked++;
		end
	end

endmodule

/* tb/tb_mem_stage.sv */
`timescale 1ns/1ns

module tb_mem_stage;
	import mem_pkg::*;

	typedef struct packed {
		alu_op_t op;
		word_t addr;
		word_t reg2;
		word_t rdata;
		word_t exc;
		word_t status;
		word_t cause;
		word_t epc;
		logic wb_we;
		cp0_addr_t wb_addr;
		word_t wb_data;
		word_t inst;
	} row_t;

	localparam word_t INST = 32'hbfc0_0100;
	localparam word_t ST_INT = 32'h0000_ff01; // all masks open, IE set
	localparam word_t CA_INT = 32'h0000_0400;

	logic clk = 1'b0;
	logic rst_i;
	alu_op_t aluop_i;
	word_t mem_addr_i, reg2_i, wdata_i, mem_data_i;
	reg_addr_t wd_i;
	logic wreg_i;
	word_t excepttype_i, current_inst_address_i;
	word_t cp0_status_i, cp0_cause_i, cp0_epc_i;
	logic wb_cp0_reg_we_i;
	cp0_addr_t wb_cp0_reg_write_addr_i;
	word_t wb_cp0_reg_data_i;
	word_t mem_addr_o, mem_data_o, wdata_o, bad_v_addr_o, cp0_epc_o;
	byte_sel_t mem_sel_o;
	logic mem_ce_o, mem_we_o, wreg_o;
	reg_addr_t wd_o;
	exc_code_t excepttype_o;

	logic [31:0] lfsr = 32'hd347;
	row_t rows[$];
	int waited;
	logic timed_out;
	string timeout_what;

	mem_stage #(.DATA_W(32)) u_dut (.*);
	mem_checker u_check (.*);

	initial begin
		forever #10 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_word();
		word_t w;
		for (int i = 0; i < 32; i++)
			w = {w[30:0], lfsr_bit()};
		return w;
	endfunction

	task automatic add_row(input alu_op_t op, input logic [1:0] off, input word_t exc,
			input word_t status, input word_t cause, input logic wb_we,
			input cp0_addr_t wb_addr, input word_t wb_data, input word_t inst);
		row_t r;
		word_t a;
		a = rand_word();
		r.op = op;
		r.addr = {a[31:2], off};
		r.reg2 = rand_word();
		r.rdata = rand_word();
		r.exc = exc;
		r.status = status;
		r.cause = cause;
		r.epc = rand_word();
		r.wb_we = wb_we;
		r.wb_addr = wb_addr;
		r.wb_data = wb_data;
		r.inst = inst;
		rows.push_back(r);
	endtask

	task automatic plain_row(input alu_op_t op, input logic [1:0] off);
		add_row(op, off, '0, '0, '0, 1'b0, '0, '0, INST);
	endtask

	task automatic build_table();
		for (int o = 0; o < 4; o++) begin
			plain_row(OP_LB, o[1:0]);
			plain_row(OP_LBU, o[1:0]);
			plain_row(OP_LWL, o[1:0]);
			plain_row(OP_LWR, o[1:0]);
			plain_row(OP_SB, o[1:0]);
			plain_row(OP_SWL, o[1:0]);
			plain_row(OP_SWR, o[1:0]);
		end
		for (int o = 0; o < 4; o += 2) begin
			plain_row(OP_LH, o[1:0]);
			plain_row(OP_LHU, o[1:0]);
			plain_row(OP_SH, o[1:0]);
		end
		plain_row(OP_LW, 2'd0);
		plain_row(OP_SW, 2'd0);
		// misaligned accesses
		plain_row(OP_LH, 2'd1);
		plain_row(OP_LHU, 2'd3);
		plain_row(OP_LW, 2'd2);
		plain_row(OP_SH, 2'd3);
		plain_row(OP_SW, 2'd1);
		plain_row(OP_SW, 2'd3);
		// priority and cp0 forwarding
		add_row(OP_LW, 2'd0, 32'h100, ST_INT, CA_INT, 1'b0, '0, '0, INST);
		add_row(OP_SW, 2'd0, '0, ST_INT, CA_INT, 1'b0, '0, '0, INST);
		add_row(OP_SW, 2'd0, '0, ST_INT, CA_INT, 1'b1, CP0_STATUS, 32'h0000_ff00, INST);
		add_row(OP_LW, 2'd0, '0, 32'h0000_ff03, CA_INT, 1'b0, '0, '0, INST);
		add_row(OP_LW, 2'd0, '0, '0, '0, 1'b1, CP0_EPC, 32'h1234_5678, INST);
		add_row(OP_LW, 2'd0, '0, ST_INT, CA_INT, 1'b1, CP0_CAUSE, '0, INST);
		add_row(OP_LW, 2'd0, '0, ST_INT, '0, 1'b1, CP0_CAUSE, CA_INT, INST);
		add_row(OP_LW, 2'd1, 32'h100, '0, '0, 1'b0, '0, '0, INST);
		add_row(OP_LW, 2'd2, 32'h100, ST_INT, CA_INT, 1'b0, '0, '0, '0);
		add_row(8'h00, 2'd0, 32'h500, '0, '0, 1'b0, '0, '0, INST);
		add_row(8'h00, 2'd0, 32'h400, '0, '0, 1'b0, '0, '0, INST);
		add_row(8'h00, 2'd0, 32'h800, '0, '0, 1'b0, '0, '0, INST);
		add_row(8'h00, 2'd0, 32'h1000, '0, '0, 1'b0, '0, '0, INST);
	endtask

	task automatic drive_row(input row_t r, input int idx);
		aluop_i = r.op;
		mem_addr_i = r.addr;
		reg2_i = r.reg2;
		mem_data_i = r.rdata;
		excepttype_i = r.exc;
		cp0_status_i = r.status;
		cp0_cause_i = r.cause;
		cp0_epc_i = r.epc;
		wb_cp0_reg_we_i = r.wb_we;
		wb_cp0_reg_write_addr_i = r.wb_addr;
		wb_cp0_reg_data_i = r.wb_data;
		current_inst_address_i = r.inst;
		wd_i = idx[4:0];
		wreg_i = ~idx[0];
		wdata_i = rand_word();
	endtask

	initial begin
		rst_i = 1'b1;
		timed_out = 1'b0;
		build_table();
		// a live store sits at the inputs through reset, none of it may get out
		drive_row(rows[0], 2);
		aluop_i = OP_SW;
		repeat (8) @(posedge clk);
		@(negedge clk);
		mem_addr_i[1:0] = 2'b01; // now a misaligned store, reset hides the fault
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		waited = 0;
		while (!u_check.reset_seen && waited < 40) begin
			@(posedge clk);
			waited++;
		end
		if (!u_check.reset_seen) begin
			timed_out = 1'b1;
			timeout_what = "the reset check";
		end

		if (!timed_out) begin
			for (int i = 0; i < rows.size(); i++) begin
				drive_row(rows[i], i);
				@(negedge clk);
			end
			drive_row('0, 0); // idle bubble at the end
			waited = 0;
			while (u_check.cycles_checked < rows.size() && waited < 100) begin
				@(posedge clk);
				waited++;
			end
			if (u_check.cycles_checked < rows.size()) begin
				timed_out = 1'b1;
				timeout_what = "the table to finish";
			end
		end

		$display("bus errors %0d, registered errors %0d, cycles checked %0d",
			u_check.bus_errors, u_check.reg_errors, u_check.cycles_checked);
		if (timed_out || u_check.bus_errors != 0 || u_check.reg_errors != 0) begin
			if (timed_out)
				$display("timeout while waiting for %s", timeout_what);
			$display("Simulation FAILED");
		end else begin
			$display("Simulation PASSED");
		end
		$finish;
	end

endmodule

/* tb.f */
rtl/mem_pkg.sv
rtl/mem_access_if.sv
rtl/mem_decode.sv
rtl/mem_execute.sv
rtl/mem_result.sv
rtl/mem_stage.sv
tb/mem_checker.sv
tb/tb_mem_stage.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_stage -f tb.f -o sim_mem_stage
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/sim_mem_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
	exit 0
fi
exit 1
